// File: src.f
design/ppu_pkg.sv
design/ppu_regs.sv
design/ppu_raster_counter.sv
design/ppu_palette_mapper.sv
design/ppu_pixel_fifo.sv
design/ppu_dispctrl.sv
design/ppu_top.sv
tests/tb_ppu.sv

// File: tests/tb_ppu.sv
/* Testbench for the PPU with APB stimulus, an LCD serial receiver and a reference
   model for registers, palette lookup, LCD conversion and pixel counts */
`timescale 1ns/1ns
`default_nettype none

module tb_ppu import ppu_pkg::*; ();

	logic      clk_ppu = 1'b0;
	logic      rst_n_ppu, psel, penable, pwrite, pready, pslverr, slverr;
	logic      lcd_cs, lcd_dc, lcd_sck, lcd_mosi;
	apb_addr_t paddr;
	apb_data_t pwdata, prdata, rd, wv;
	integer    seed = 11839;
	int        mismatches = 0;
	int        timeouts = 0;
	int        rx_count = 0;
	int        rx_width = 16;
	int        w, h, n, i, k;
	lcd_pix_t  rx_shift = '0;
	lcd_pix_t  rx_words[$];
	lcd_pix_t  sent[$];
	pixdata_t  pal_model [N_PALETTE];
	pixdata_t  colour;
	pal_idx_t  idx;

	ppu_top uut (
		.clk_ppu, .rst_n_ppu, .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
		.paddr_i (paddr), .pwdata_i (pwdata), .prdata_o (prdata), .pready_o (pready),
		.pslverr_o (pslverr), .lcd_cs_o (lcd_cs), .lcd_dc_o (lcd_dc),
		.lcd_sck_o (lcd_sck), .lcd_mosi_o (lcd_mosi)
	);

	always #5 clk_ppu = ~clk_ppu;

	// LCD receiver shifting in MSB first
	// Word width follows the stimulus
	always @(posedge lcd_sck) begin
		rx_shift = {rx_shift[14:0], lcd_mosi};
		rx_count++;
		if (rx_count == rx_width) begin
			rx_words.push_back(rx_shift);
			rx_shift = '0;
			rx_count = 0;
		end
	end

	// RGB555 to RGB565 with green widened by a zero LSB
	function automatic lcd_pix_t to_lcd(input pixdata_t c);
		logic [4:0] red, green, blue;
		red   = c[14:10];
		green = c[9:5];
		blue  = c[4:0];
		return {red, green, 1'b0, blue};
	endfunction

	task automatic check_value(input apb_data_t actual, input apb_data_t expected,
		input string msg);
		if (actual !== expected) begin
			mismatches++;
			$display("Mismatch at %0t ns: %s, got %h, expected %h", $time, msg, actual,
				expected);
		end
	endtask

	task automatic finish_run;
		$display("Checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	endtask

	// ----------------------------------------
	// APB access starting and ending 1 ns after a rising edge
	task automatic bus_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
		output apb_data_t rdata, output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk_ppu);
		#1 penable = 1'b1;
		@(negedge clk_ppu);
		rdata = prdata;
		err   = pslverr;
		check_value(pready, 1, "pready in access phase");
		@(posedge clk_ppu);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
		apb_data_t rdata;
		logic      err;
		bus_access(1'b1, addr, data, rdata, err);
		check_value(err, 0, $sformatf("pslverr on write to %h", addr));
	endtask

	task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
		logic err;
		bus_access(1'b0, addr, '0, data, err);
		check_value(err, 0, $sformatf("pslverr on read of %h", addr));
	endtask

	task automatic wait_words(input int count);
		int cycles;
		cycles = 0;
		while (rx_words.size() < count && cycles < 5000) begin
			@(posedge clk_ppu);
			#1 cycles++;
		end
		if (rx_words.size() < count) begin
			timeouts++;
			$display("Timeout: only %0d of %0d LCD words arrived", rx_words.size(), count);
			finish_run();
		end
	endtask

	// Not running, FIFO empty, shifter idle
	task automatic wait_idle;
		apb_data_t csr;
		int        polls;
		polls = 0;
		csr   = '1;
		while ((csr & 32'h701) != 32'h100 && polls < 200) begin
			read_reg(REG_CSR, csr);
			polls++;
		end
		if ((csr & 32'h701) != 32'h100) begin
			timeouts++;
			$display("Timeout: the unit never went idle, CSR reads %h", csr);
			finish_run();
		end
	endtask

	task automatic check_words(input int count, input lcd_pix_t expected, input string what);
		check_value(rx_words.size(), count, {what, " word count"});
		foreach (rx_words[j])
			check_value(rx_words[j], expected, $sformatf("%s word %0d", what, j));
	endtask

	task automatic run_frame(input apb_data_t csr_val, input int count);
		rx_words.delete();
		write_reg(REG_CSR, csr_val);
		wait_words(count);
		wait_idle();
	endtask

	initial begin
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		rst_n_ppu = 1'b0;
		repeat (4) @(posedge clk_ppu);
		#1 rst_n_ppu = 1'b1;

		// ----------------------------------------
		// Reset values and register read-back
		read_reg(REG_DISPSIZE, rd);
		check_value(rd, 32'h0003_0007, "DISPSIZE after reset");
		read_reg(REG_LCD_CSR, rd);
		check_value(rd, 32'h1, "LCD_CSR after reset");
		read_reg(REG_CSR, rd);
		check_value(rd, 32'h100, "CSR after reset");
		for (i = 0; i < 4; i++) begin
			wv = $random(seed);
			write_reg(REG_DISPSIZE, wv);
			read_reg(REG_DISPSIZE, rd);
			check_value(rd, wv & 32'h00FF_01FF, "DISPSIZE read-back");
			wv = $random(seed);
			write_reg(REG_DEFAULT_BG, wv);
			read_reg(REG_DEFAULT_BG, rd);
			check_value(rd, wv & 32'h0000_FFFF, "DEFAULT_BG read-back");
			wv = $random(seed);
			write_reg(REG_LCD_CSR, wv);
			read_reg(REG_LCD_CSR, rd);
			check_value(rd, wv & 32'h7, "LCD_CSR read-back");
			check_value(lcd_cs, wv[0], "lcd_cs_o");
			check_value(lcd_dc, wv[1], "lcd_dc_o");
		end
		bus_access(1'b0, 16'h0018, '0, rd, slverr);
		check_value(slverr, 1, "pslverr on unmapped read");
		bus_access(1'b1, 16'h0400, '0, rd, slverr);
		check_value(slverr, 1, "pslverr on unmapped write");
		bus_access(1'b0, PRAM_BASE + 16'h2, '0, rd, slverr);
		check_value(slverr, 1, "pslverr on palette read");

		// ----------------------------------------
		// Direct push of 16-bit and then 8-bit words
		write_reg(REG_LCD_CSR, 32'h0);
		rx_width = 16;
		rx_words.delete();
		for (i = 0; i < 6; i++) begin
			wv = $random(seed);
			sent.push_back(wv[15:0]);
			write_reg(REG_LCD_PXFIFO, wv);
		end
		wait_words(6);
		wait_idle();
		check_value(rx_words.size(), 6, "16-bit push word count");
		foreach (rx_words[j])
			check_value(rx_words[j], sent[j], $sformatf("16-bit push word %0d", j));
		write_reg(REG_LCD_CSR, 32'h4);
		rx_width = 8;
		rx_words.delete();
		sent.delete();
		for (i = 0; i < 6; i++) begin
			wv = $random(seed);
			sent.push_back({8'h00, wv[7:0]});
			write_reg(REG_LCD_PXFIFO, wv);
		end
		wait_words(6);
		wait_idle();
		check_value(rx_words.size(), 6, "8-bit push word count");
		foreach (rx_words[j])
			check_value(rx_words[j], sent[j], $sformatf("8-bit push word %0d", j));
		write_reg(REG_LCD_CSR, 32'h0);
		rx_width = 16;

		// ----------------------------------------
		// Direct-colour frame with frame halt
		w      = $unsigned($random(seed)) % 6;
		h      = $unsigned($random(seed)) % 4;
		n      = (w + 1) * (h + 1);
		colour = $random(seed);
		write_reg(REG_DISPSIZE, (h << 16) | w);
		write_reg(REG_DEFAULT_BG, {17'b0, colour});
		run_frame(32'h9, n);
		check_words(n, to_lcd(colour), "direct frame");
		read_reg(REG_CSR, rd);
		check_value(rd, 32'h108, "CSR after direct frame");
		read_reg(REG_BEAM, rd);
		check_value(rd, 32'h0, "BEAM after direct frame");

		// Paletted frame
		for (i = 0; i < 16; i++) begin
			k  = $unsigned($random(seed)) % N_PALETTE;
			// Bits above the colour field carry random junk
			wv = $random(seed);
			pal_model[k] = wv[14:0];
			write_reg(apb_addr_t'(PRAM_BASE + 2 * k), wv);
			// Look up the first entry written, later writes land elsewhere
			if (i == 0)
				idx = k;
		end
		wv  = $random(seed);
		write_reg(REG_DEFAULT_BG, (wv & 32'h7F00) | 32'h8000 | idx);
		run_frame(32'h9, n);
		check_words(n, to_lcd(pal_model[idx]), "paletted frame");

		// Row halt only
		run_frame(32'h5, w + 1);
		check_words(w + 1, to_lcd(pal_model[idx]), "row halt");
		read_reg(REG_BEAM, rd);
		check_value(rd, (h == 0) ? 32'h0 : 32'h0001_0000, "BEAM after row halt");

		finish_run();
	end

endmodule

`default_nettype wire

// File: design/ppu_top.sv
/* PPU top: run/halt control, background pixel source, LCD conversion
   and the display path instances */
`timescale 1ns/1ns
`default_nettype none

module ppu_top import ppu_pkg::*; (
	input  wire logic      clk_ppu,
	input  wire logic      rst_n_ppu,
	input  wire logic      psel_i,
	input  wire logic      penable_i,
	input  wire logic      pwrite_i,
	input  wire apb_addr_t paddr_i,
	input  wire apb_data_t pwdata_i,
	output apb_data_t      prdata_o,
	output logic           pready_o,
	output logic           pslverr_o,
	output logic           lcd_cs_o,
	output logic           lcd_dc_o,
	output logic           lcd_sck_o,
	output logic           lcd_mosi_o
);

	logic     csr_run, csr_halt, halt_hsync, halt_vsync;
	logic     running_reg, running;
	coord_x_t last_x, beam_x;
	coord_y_t last_y, beam_y;
	logic     start_row, start_frame, advance;
	pixdata_t bg_colour, pmap_out_data, pram_wdata;
	logic     bg_paletted, pmap_in_rdy, pmap_out_vld, pmap_out_rdy;
	logic     pram_wen;
	pal_idx_t pram_waddr;
	logic     direct_wen, fifo_push, fifo_full, fifo_empty, fifo_pop;
	lcd_pix_t direct_wdata, fifo_wdata, fifo_rdata;
	logic     shift8, tx_busy;

	// ----------------------------------------
	// Run/halt control
	// Sync pulses are registered, so the halt lands exactly on the boundary
	assign running = running_reg &&
		!(halt_hsync && start_row || halt_vsync && start_frame);

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu)
			running_reg <= 1'b0;
		else
			running_reg <= (running || csr_run) && !csr_halt;
	end

	// Default colour is the only pixel source
	assign advance = running && pmap_in_rdy;

	// ----------------------------------------
	// FIFO write port, direct push wins
	assign pmap_out_rdy = !fifo_full && !direct_wen;
	assign fifo_push    = direct_wen || (pmap_out_vld && pmap_out_rdy);
	// RGB555 to RGB565 with a zero green LSB
	assign fifo_wdata   = direct_wen ? direct_wdata :
		{pmap_out_data[14:5], 1'b0, pmap_out_data[4:0]};

	ppu_regs regs_u (
		.clk_ppu, .rst_n_ppu, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
		.prdata_o, .pready_o, .pslverr_o,
		.run_o (csr_run), .halt_o (csr_halt),
		.halt_hsync_o (halt_hsync), .halt_vsync_o (halt_vsync),
		.running_i (running), .beam_x_i (beam_x), .beam_y_i (beam_y),
		.pxfifo_empty_i (fifo_empty), .pxfifo_full_i (fifo_full), .tx_busy_i (tx_busy),
		.last_x_o (last_x), .last_y_o (last_y),
		.bg_colour_o (bg_colour), .bg_paletted_o (bg_paletted),
		.pram_wen_o (pram_wen), .pram_waddr_o (pram_waddr), .pram_wdata_o (pram_wdata),
		.direct_wen_o (direct_wen), .direct_wdata_o (direct_wdata),
		.lcd_cs_o, .lcd_dc_o, .shift8_o (shift8)
	);

	ppu_raster_counter raster_u (
		.clk_ppu, .rst_n_ppu, .advance_i (advance),
		.last_x_i (last_x), .last_y_i (last_y), .x_o (beam_x), .y_o (beam_y),
		.start_row_o (start_row), .start_frame_o (start_frame)
	);

	ppu_palette_mapper pmap_u (
		.clk_ppu, .rst_n_ppu,
		.in_vld_i (running), .in_rdy_o (pmap_in_rdy),
		.in_data_i (bg_colour), .in_paletted_i (bg_paletted),
		.pram_wen_i (pram_wen), .pram_waddr_i (pram_waddr), .pram_wdata_i (pram_wdata),
		.out_vld_o (pmap_out_vld), .out_rdy_i (pmap_out_rdy), .out_data_o (pmap_out_data)
	);

	ppu_pixel_fifo pxfifo_u (
		.clk_ppu, .rst_n_ppu, .wdata_i (fifo_wdata), .push_i (fifo_push),
		.full_o (fifo_full), .empty_o (fifo_empty), .level_o (),
		.rdata_o (fifo_rdata), .pop_i (fifo_pop)
	);

	ppu_dispctrl dispctrl_u (
		.clk_ppu, .rst_n_ppu, .fifo_vld_i (!fifo_empty), .fifo_pop_o (fifo_pop),
		.fifo_rdata_i (fifo_rdata), .shift8_i (shift8), .busy_o (tx_busy),
		.lcd_sck_o, .lcd_mosi_o
	);

endmodule

`default_nettype wire

// File: design/ppu_dispctrl.sv
/* LCD serial shifter: pops FIFO words, sends them MSB first
   with two cycles per bit */
`timescale 1ns/1ns
`default_nettype none

module ppu_dispctrl import ppu_pkg::*; (
	input  wire logic     clk_ppu,
	input  wire logic     rst_n_ppu,
	input  wire logic     fifo_vld_i,
	output logic          fifo_pop_o,
	input  wire lcd_pix_t fifo_rdata_i,
	input  wire logic     shift8_i,
	output logic          busy_o,
	output logic          lcd_sck_o,
	output logic          lcd_mosi_o
);

	shift_state_t state;
	lcd_pix_t     shreg;
	logic [3:0]   bits_left;
	logic         last_bit;

	assign last_bit   = (state == HIGH) && (bits_left == 4'd0);
	// Back-to-back words: reload straight out of the last high phase
	assign fifo_pop_o = fifo_vld_i && (state == IDLE || last_bit);

	assign busy_o     = state != IDLE;
	assign lcd_sck_o  = state == HIGH;
	assign lcd_mosi_o = shreg[15];

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			state     <= IDLE;
			shreg     <= '0;
			bits_left <= '0;
		end else if (fifo_pop_o) begin
			state <= LOW;
			// 8-bit mode sends the low byte, left-aligned
			if (shift8_i) begin
				shreg     <= {fifo_rdata_i[7:0], 8'h00};
				bits_left <= 4'd7;
			end else begin
				shreg     <= fifo_rdata_i;
				bits_left <= 4'd15;
			end
		end else begin
			case (state)
				LOW: begin
					state <= HIGH;
				end
				HIGH: begin
					if (last_bit) begin
						state <= IDLE;
					end else begin
						state     <= LOW;
						shreg     <= shreg << 1;
						bits_left <= bits_left - 1'b1;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/ppu_pixel_fifo.sv
/* Synchronous pixel FIFO with full, empty and level status */
`timescale 1ns/1ns
`default_nettype none

module ppu_pixel_fifo import ppu_pkg::*; (
	input  wire logic     clk_ppu,
	input  wire logic     rst_n_ppu,
	input  wire lcd_pix_t wdata_i,
	input  wire logic     push_i,
	output logic          full_o,
	output logic          empty_o,
	output pxfifo_level_t level_o,
	output lcd_pix_t      rdata_o,
	input  wire logic     pop_i
);

	lcd_pix_t mem [PXFIFO_DEPTH];
	logic [$clog2(PXFIFO_DEPTH)-1:0] wptr, rptr;
	logic do_push, do_pop;

	assign full_o  = level_o == pxfifo_level_t'(PXFIFO_DEPTH);
	assign empty_o = level_o == '0;
	// Overflow and underflow are ignored
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;
	assign rdata_o = mem[rptr];

	always_ff @(posedge clk_ppu) begin
		if (do_push)
			mem[wptr] <= wdata_i;
	end

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			wptr    <= '0;
			rptr    <= '0;
			level_o <= '0;
		end else begin
			if (do_push)
				wptr <= wptr + 1'b1;
			if (do_pop)
				rptr <= rptr + 1'b1;
			if (do_push && !do_pop)
				level_o <= level_o + 1'b1;
			else if (do_pop && !do_push)
				level_o <= level_o - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: design/ppu_palette_mapper.sv
/* Palette RAM with a single-stage lookup, valid/ready on both sides */
`timescale 1ns/1ns
`default_nettype none

module ppu_palette_mapper import ppu_pkg::*; (
	input  wire logic     clk_ppu,
	input  wire logic     rst_n_ppu,
	input  wire logic     in_vld_i,
	output logic          in_rdy_o,
	input  wire pixdata_t in_data_i,
	input  wire logic     in_paletted_i,
	input  wire logic     pram_wen_i,
	input  wire pal_idx_t pram_waddr_i,
	input  wire pixdata_t pram_wdata_i,
	output logic          out_vld_o,
	input  wire logic     out_rdy_i,
	output pixdata_t      out_data_o
);

	pixdata_t pram [N_PALETTE];
	pal_idx_t lut_idx;
	logic     in_xfer;

	always_ff @(posedge clk_ppu) begin
		if (pram_wen_i)
			pram[pram_waddr_i] <= pram_wdata_i;
	end

	// Output stage is free when empty or being drained
	assign in_rdy_o = !out_vld_o || out_rdy_i;
	assign in_xfer  = in_vld_i && in_rdy_o;
	// Index lives in the low byte of a paletted pixel
	assign lut_idx  = in_data_i[7:0];

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu)
			out_vld_o <= 1'b0;
		else if (in_xfer)
			out_vld_o <= 1'b1;
		else if (out_rdy_i)
			out_vld_o <= 1'b0;
	end

	always_ff @(posedge clk_ppu) begin
		if (in_xfer)
			out_data_o <= in_paletted_i ? pram[lut_idx] : in_data_i;
	end

endmodule

`default_nettype wire

// File: design/ppu_raster_counter.sv
/* Beam X/Y counter with registered row-start and frame-start pulses */
`timescale 1ns/1ns
`default_nettype none

module ppu_raster_counter import ppu_pkg::*; (
	input  wire logic     clk_ppu,
	input  wire logic     rst_n_ppu,
	input  wire logic     advance_i,
	input  wire coord_x_t last_x_i,
	input  wire coord_y_t last_y_i,
	output coord_x_t      x_o,
	output coord_y_t      y_o,
	output logic          start_row_o,
	output logic          start_frame_o
);

	logic end_of_row, end_of_frame;

	assign end_of_row   = x_o == last_x_i;
	assign end_of_frame = end_of_row && (y_o == last_y_i);

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			x_o           <= '0;
			y_o           <= '0;
			start_row_o   <= 1'b0;
			start_frame_o <= 1'b0;
		end else begin
			// Pulses land one cycle after the wrapping advance
			start_row_o   <= advance_i && end_of_row;
			start_frame_o <= advance_i && end_of_frame;
			if (advance_i) begin
				if (end_of_row) begin
					x_o <= '0;
					y_o <= end_of_frame ? '0 : y_o + 1'b1;
				end else begin
					x_o <= x_o + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/ppu_regs.sv
/* APB register block: run/halt strobes, display size, background colour,
   palette write port, direct pixel push and LCD control */
`timescale 1ns/1ns
`default_nettype none

module ppu_regs import ppu_pkg::*; (
	input  wire logic      clk_ppu,
	input  wire logic      rst_n_ppu,
	input  wire logic      psel_i,
	input  wire logic      penable_i,
	input  wire logic      pwrite_i,
	input  wire apb_addr_t paddr_i,
	input  wire apb_data_t pwdata_i,
	output apb_data_t      prdata_o,
	output logic           pready_o,
	output logic           pslverr_o,
	output logic           run_o,
	output logic           halt_o,
	output logic           halt_hsync_o,
	output logic           halt_vsync_o,
	input  wire logic      running_i,
	input  wire coord_x_t  beam_x_i,
	input  wire coord_y_t  beam_y_i,
	input  wire logic      pxfifo_empty_i,
	input  wire logic      pxfifo_full_i,
	input  wire logic      tx_busy_i,
	output coord_x_t       last_x_o,
	output coord_y_t       last_y_o,
	output pixdata_t       bg_colour_o,
	output logic           bg_paletted_o,
	output logic           pram_wen_o,
	output pal_idx_t       pram_waddr_o,
	output pixdata_t       pram_wdata_o,
	output logic           direct_wen_o,
	output lcd_pix_t       direct_wdata_o,
	output logic           lcd_cs_o,
	output logic           lcd_dc_o,
	output logic           shift8_o
);

	logic access, wr_en;
	logic hit_csr, hit_size, hit_beam, hit_bg, hit_pxfifo, hit_lcd, hit_pram;

	// ----------------------------------------
	// Address decode, access phase only
	assign access = psel_i && penable_i;
	assign wr_en  = access && pwrite_i;

	assign hit_csr    = paddr_i == REG_CSR;
	assign hit_size   = paddr_i == REG_DISPSIZE;
	assign hit_beam   = paddr_i == REG_BEAM;
	assign hit_bg     = paddr_i == REG_DEFAULT_BG;
	assign hit_pxfifo = paddr_i == REG_LCD_PXFIFO;
	assign hit_lcd    = paddr_i == REG_LCD_CSR;
	// 256 halfword entries span 0x800..0x9ff
	assign hit_pram   = paddr_i[15:9] == PRAM_BASE[15:9];

	assign pready_o  = 1'b1;
	// Palette is write-only
	assign pslverr_o = access && (hit_pram ? !pwrite_i :
		!(hit_csr || hit_size || hit_beam || hit_bg || hit_pxfifo || hit_lcd));

	// Single-cycle strobes
	assign run_o          = wr_en && hit_csr && pwdata_i[0];
	assign halt_o         = wr_en && hit_csr && pwdata_i[1];
	assign direct_wen_o   = wr_en && hit_pxfifo;
	assign direct_wdata_o = pwdata_i[15:0];
	assign pram_wen_o     = wr_en && hit_pram;
	assign pram_waddr_o   = paddr_i[8:1];
	assign pram_wdata_o   = pwdata_i[14:0];

	// ----------------------------------------
	// Stored configuration
	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			halt_hsync_o  <= 1'b0;
			halt_vsync_o  <= 1'b0;
			last_x_o      <= 9'd7;
			last_y_o      <= 8'd3;
			bg_colour_o   <= '0;
			bg_paletted_o <= 1'b0;
			lcd_cs_o      <= 1'b1;
			lcd_dc_o      <= 1'b0;
			shift8_o      <= 1'b0;
		end else if (wr_en) begin
			if (hit_csr) begin
				halt_hsync_o <= pwdata_i[2];
				halt_vsync_o <= pwdata_i[3];
			end
			if (hit_size) begin
				last_x_o <= pwdata_i[8:0];
				last_y_o <= pwdata_i[23:16];
			end
			if (hit_bg) begin
				bg_colour_o   <= pwdata_i[14:0];
				bg_paletted_o <= pwdata_i[15];
			end
			if (hit_lcd) begin
				lcd_cs_o <= pwdata_i[0];
				lcd_dc_o <= pwdata_i[1];
				shift8_o <= pwdata_i[2];
			end
		end
	end

	// Read data mux
	always_comb begin
		prdata_o = '0;
		if (hit_csr)
			prdata_o = {21'b0, tx_busy_i, pxfifo_full_i, pxfifo_empty_i, 4'b0,
				halt_vsync_o, halt_hsync_o, 1'b0, running_i};
		else if (hit_size)
			prdata_o = {8'b0, last_y_o, 7'b0, last_x_o};
		else if (hit_beam)
			prdata_o = {8'b0, beam_y_i, 7'b0, beam_x_i};
		else if (hit_bg)
			prdata_o = {16'b0, bg_paletted_o, bg_colour_o};
		else if (hit_lcd)
			prdata_o = {29'b0, shift8_o, lcd_dc_o, lcd_cs_o};
	end

endmodule

`default_nettype wire

// File: design/ppu_pkg.sv
/* Shared widths, vector types, register map offsets and the
   LCD shifter state encoding */
`default_nettype none

package ppu_pkg;

	// Sizes
	localparam int PXFIFO_DEPTH = 8;
	localparam int N_PALETTE    = 256;

	// ----------------------------------------
	// Vector types
	typedef logic [8:0]  coord_x_t;
	typedef logic [7:0]  coord_y_t;
	// RGB555, red in the top bits
	typedef logic [14:0] pixdata_t;
	typedef logic [15:0] lcd_pix_t;
	typedef logic [7:0]  pal_idx_t;
	typedef logic [15:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;
	typedef logic [3:0]  pxfifo_level_t;

	// ----------------------------------------
	// Register map
	localparam apb_addr_t REG_CSR        = 16'h0000;
	localparam apb_addr_t REG_DISPSIZE   = 16'h0004;
	localparam apb_addr_t REG_BEAM       = 16'h0008;
	localparam apb_addr_t REG_DEFAULT_BG = 16'h000C;
	localparam apb_addr_t REG_LCD_PXFIFO = 16'h0010;
	localparam apb_addr_t REG_LCD_CSR    = 16'h0014;
	// Palette entry n sits at PRAM_BASE + 2n
	localparam apb_addr_t PRAM_BASE      = 16'h0800;

	// LCD serial shifter
	typedef enum logic [1:0] {
		IDLE,
		LOW,
		HIGH
	} shift_state_t;

endpackage

`default_nettype wire
